// File: hw/cache_pkg.sv
// Defaults only. Real sizes come from cache_top parameters and must pass geometry_ok
package cache_pkg;

	// ==============================
	// Default geometry
	// ==============================

	// Sets per way, must be a power of two
	localparam int DEF_LINES      = 64;
	localparam int DEF_WAYS       = 4;
	localparam int DEF_AWID       = 32;
	// Sixteen byte lines leave four offset bits in the address
	localparam int DEF_LINE_BYTES = 16;
	localparam int DEF_DATA_W     = 128;

	// Way count limits for the victim pointer and the way encoder
	localparam int MIN_WAYS = 2;
	localparam int MAX_WAYS = 8;

	// True when the sizes form a cache this design can build
	function automatic bit geometry_ok(int lines, int ways, int awid, int line_bytes,
		int data_w);
		bit ok;
		ok = (ways >= MIN_WAYS) && (ways <= MAX_WAYS);
		ok = ok && ((1 << $clog2(ways)) == ways);
		ok = ok && ((1 << $clog2(lines)) == lines);
		ok = ok && ((1 << $clog2(line_bytes)) == line_bytes);
		// At least one tag bit has to remain above index and offset
		ok = ok && ($clog2(lines) + $clog2(line_bytes) < awid);
		ok = ok && (data_w == 8 * line_bytes);
		return ok;
	endfunction

endpackage

// File: hw/cache_tag_if.sv
// Tag read bus. TAG_W must equal the address width less index and offset bits
`timescale 1ns/1ps

interface cache_tag_if #(
	parameter int LINES = cache_pkg::DEF_LINES,
	parameter int WAYS  = cache_pkg::DEF_WAYS,
	parameter int TAG_W = cache_pkg::DEF_AWID - $clog2(cache_pkg::DEF_LINES)
		- $clog2(cache_pkg::DEF_LINE_BYTES)
);

	// Set index of the lookup, used as the tag read address
	logic [$clog2(LINES)-1:0] ndx;
	// Tag of the looked-up address, held until the read data is back
	logic [TAG_W-1:0] cmp_tag;
	// Stored tag of each way in the set that was read
	logic [WAYS-1:0][TAG_W-1:0] tags;
	// Valid bit of each way in the set that was read
	logic [WAYS-1:0] valid_bits;

	// The store gets the read address and returns the set
	modport store (input ndx, output tags, valid_bits);

	// The hit detector only looks at the returned set and the compare tag
	modport hit (input cmp_tag, tags, valid_bits);

endinterface

// File: hw/cache_tag_store.sv
// One-cycle tag read. Invalidate beats a fill of the same cycle for the valid bit
`timescale 1ns/1ps

module cache_tag_store #(
	parameter int LINES      = cache_pkg::DEF_LINES,
	parameter int WAYS       = cache_pkg::DEF_WAYS,
	parameter int AWID       = cache_pkg::DEF_AWID,
	parameter int LINE_BYTES = cache_pkg::DEF_LINE_BYTES,
	parameter int DATA_W     = cache_pkg::DEF_DATA_W
) (
	input  logic                                             clk,
	input  logic                                             rst_n,
	input  logic                                             fill,
	input  logic                                             invalidate,
	input  logic [$clog2(LINES)-1:0]                         fill_ndx,
	input  logic [AWID-$clog2(LINES)-$clog2(LINE_BYTES)-1:0] fill_tag,
	input  logic [$clog2(WAYS)-1:0]                          victim_way,
	input  logic                                             rd_en,
	cache_tag_if.store                                       tag_bus,
	output logic [WAYS-1:0]                                  fill_valid_bits
);
	import cache_pkg::*;

	localparam int IDX_W = $clog2(LINES);
	localparam int OFF_W = $clog2(LINE_BYTES);
	localparam int TAG_W = AWID - IDX_W - OFF_W;

	// Tag RAM, one row per set in each way
	logic [TAG_W-1:0] tag_mem [WAYS][LINES];
	// Valid flags are flops so that reset and invalidate can clear them at once
	logic [LINES-1:0] valid [WAYS];

	// Read registers that hand the set to the hit detector
	logic [WAYS-1:0][TAG_W-1:0] tags_q;
	logic [WAYS-1:0]            valid_q;

	if (!geometry_ok(LINES, WAYS, AWID, LINE_BYTES, DATA_W)) begin : g_bad_geometry
		$error("cache_tag_store: unsupported cache geometry");
	end

	// ==============================
	// Fill side
	// ==============================

	// Only the victim way takes the new tag
	always_ff @(posedge clk)
	begin
		if (fill)
			tag_mem[victim_way][fill_ndx] <= fill_tag;
	end

	// Invalidate wipes every set of every way in one cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n || invalidate)
		begin
			for (int w = 0; w < WAYS; w++)
				valid[w] <= '0;
		end
		else if (fill)
			valid[victim_way][fill_ndx] <= 1'b1;
	end

	// The victim chooser looks at the set being filled
	always_comb
	begin
		for (int w = 0; w < WAYS; w++)
			fill_valid_bits[w] = valid[w][fill_ndx];
	end

	// ==============================
	// Lookup side
	// ==============================

	// Both tags and valid bits come out one cycle after rd_en
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			for (int w = 0; w < WAYS; w++)
			begin
				tags_q[w]  <= tag_mem[w][tag_bus.ndx];
				valid_q[w] <= valid[w][tag_bus.ndx];
			end
		end
	end

	assign tag_bus.tags       = tags_q;
	assign tag_bus.valid_bits = valid_q;

endmodule

// File: hw/cache_hit.sv
// Inputs must come from a registered tag read. hit is only high while ce is high
`timescale 1ns/1ps

module cache_hit #(
	parameter int LINES      = cache_pkg::DEF_LINES,
	parameter int WAYS       = cache_pkg::DEF_WAYS,
	parameter int AWID       = cache_pkg::DEF_AWID,
	parameter int LINE_BYTES = cache_pkg::DEF_LINE_BYTES,
	parameter int DATA_W     = cache_pkg::DEF_DATA_W
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    ce,
	cache_tag_if.hit                tag_bus,
	output logic                    hit,
	output logic [$clog2(WAYS)-1:0] rway,
	output logic                    cv
);
	import cache_pkg::*;

	localparam int WAY_W = $clog2(WAYS);

	// One bit per way that matches and holds a valid line
	logic [WAYS-1:0]  match;
	logic [WAY_W-1:0] prev_rway;
	logic             any_valid;

	if (!geometry_ok(LINES, WAYS, AWID, LINE_BYTES, DATA_W)) begin : g_bad_geometry
		$error("cache_hit: unsupported cache geometry");
	end

	// ==============================
	// Tag compare
	// ==============================

	// The compare is qualified with ce so that an idle cycle never reports a hit
	always_comb
	begin
		for (int w = 0; w < WAYS; w++)
			match[w] = ce && tag_bus.valid_bits[w] && (tag_bus.tags[w] == tag_bus.cmp_tag);
	end

	assign hit = |match;

	// A tag lives in one way at most, so the encoder needs no priority
	always_comb
	begin
		rway = prev_rway;
		for (int w = 0; w < WAYS; w++)
			if (match[w])
				rway = w[WAY_W-1:0];
	end

	// A miss keeps showing the way of the last hit
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			prev_rway <= '0;
		else if (ce)
			prev_rway <= rway;
	end

	// ==============================
	// Set valid flag
	// ==============================

	assign any_valid = |tag_bus.valid_bits;

	// Second stage of the cv pipe, the tag store read register being the first
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cv <= 1'b0;
		else if (ce)
			cv <= any_valid;
	end

endmodule

// File: hw/cache_victim.sv
// Round-robin pointers survive invalidate and only move when a full set is filled
`timescale 1ns/1ps

module cache_victim #(
	parameter int LINES      = cache_pkg::DEF_LINES,
	parameter int WAYS       = cache_pkg::DEF_WAYS,
	parameter int AWID       = cache_pkg::DEF_AWID,
	parameter int LINE_BYTES = cache_pkg::DEF_LINE_BYTES,
	parameter int DATA_W     = cache_pkg::DEF_DATA_W
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     fill,
	input  logic [$clog2(LINES)-1:0] fill_ndx,
	input  logic [WAYS-1:0]          fill_valid_bits,
	output logic [$clog2(WAYS)-1:0]  victim_way
);
	import cache_pkg::*;

	localparam int WAY_W = $clog2(WAYS);

	// Next way to evict in each set once all ways hold lines
	logic [WAY_W-1:0] rr_ptr [LINES];
	logic             set_full;

	if (!geometry_ok(LINES, WAYS, AWID, LINE_BYTES, DATA_W)) begin : g_bad_geometry
		$error("cache_victim: unsupported cache geometry");
	end

	assign set_full = &fill_valid_bits;

	// Walking down leaves the lowest free way as the choice
	always_comb
	begin
		victim_way = rr_ptr[fill_ndx];
		for (int w = WAYS - 1; w >= 0; w--)
			if (!fill_valid_bits[w])
				victim_way = w[WAY_W-1:0];
	end

	// WAYS is a power of two, so the pointer wraps by itself
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < LINES; s++)
				rr_ptr[s] <= '0;
		end
		// Fills into a free way leave the pointer where it was
		else if (fill && set_full)
			rr_ptr[fill_ndx] <= rr_ptr[fill_ndx] + 1'b1;
	end

endmodule

// File: hw/cache_data_store.sv
// Line data RAM without reset. rdata means nothing unless hit is high
`timescale 1ns/1ps

module cache_data_store #(
	parameter int LINES      = cache_pkg::DEF_LINES,
	parameter int WAYS       = cache_pkg::DEF_WAYS,
	parameter int AWID       = cache_pkg::DEF_AWID,
	parameter int LINE_BYTES = cache_pkg::DEF_LINE_BYTES,
	parameter int DATA_W     = cache_pkg::DEF_DATA_W
) (
	input  logic                     clk,
	input  logic                     fill,
	input  logic [$clog2(LINES)-1:0] fill_ndx,
	input  logic [$clog2(WAYS)-1:0]  victim_way,
	input  logic [DATA_W-1:0]        fill_data,
	input  logic                     rd_en,
	input  logic [$clog2(LINES)-1:0] rd_ndx,
	input  logic [$clog2(WAYS)-1:0]  rd_way,
	output logic [DATA_W-1:0]        rdata
);
	import cache_pkg::*;

	// One line per set in each way
	logic [DATA_W-1:0] data_mem [WAYS][LINES];
	// Every way of the set that was read, waiting for the hit way
	logic [DATA_W-1:0] set_q [WAYS];

	if (!geometry_ok(LINES, WAYS, AWID, LINE_BYTES, DATA_W)) begin : g_bad_geometry
		$error("cache_data_store: unsupported cache geometry");
	end

	// The fill line goes into the way the victim chooser picked
	always_ff @(posedge clk)
	begin
		if (fill)
			data_mem[victim_way][fill_ndx] <= fill_data;
	end

	// The whole set is read because the hit way is not known yet
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			for (int w = 0; w < WAYS; w++)
				set_q[w] <= data_mem[w][rd_ndx];
		end
	end

	// rd_way arrives in the response cycle from the way encoder
	assign rdata = set_q[rd_way];

endmodule

// File: hw/cache_top.sv
// Lookup and fill share adr and must not come in the same cycle. Misses fetch nothing
`timescale 1ns/1ps

module cache_top #(
	parameter int LINES      = cache_pkg::DEF_LINES,
	parameter int WAYS       = cache_pkg::DEF_WAYS,
	parameter int AWID       = cache_pkg::DEF_AWID,
	parameter int LINE_BYTES = cache_pkg::DEF_LINE_BYTES,
	parameter int DATA_W     = cache_pkg::DEF_DATA_W
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    lookup,
	input  logic                    fill,
	input  logic                    invalidate,
	input  logic [AWID-1:0]         adr,
	input  logic [DATA_W-1:0]       fill_data,
	output logic                    resp_valid,
	output logic                    hit,
	output logic [$clog2(WAYS)-1:0] rway,
	output logic [DATA_W-1:0]       rdata,
	output logic                    cv
);
	import cache_pkg::*;

	localparam int IDX_W = $clog2(LINES);
	localparam int OFF_W = $clog2(LINE_BYTES);
	localparam int TAG_W = AWID - IDX_W - OFF_W;
	localparam int WAY_W = $clog2(WAYS);

	logic [IDX_W-1:0] adr_ndx;
	logic [TAG_W-1:0] adr_tag;
	// Lookup tag held for the compare in the response cycle
	logic [TAG_W-1:0] cmp_tag_q;
	logic [WAY_W-1:0] victim_way;
	logic [WAYS-1:0]  fill_valid_bits;

	if (!geometry_ok(LINES, WAYS, AWID, LINE_BYTES, DATA_W)) begin : g_bad_geometry
		$error("cache_top: unsupported cache geometry");
	end

	// ==============================
	// Address split
	// ==============================

	// Offset bits pick a byte inside the line and play no part in the lookup
	assign adr_ndx = adr[OFF_W +: IDX_W];
	assign adr_tag = adr[AWID-1 -: TAG_W];

	// resp_valid also times the hit detector, so it is the cache_hit ce
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			resp_valid <= 1'b0;
		else
			resp_valid <= lookup;
	end

	always_ff @(posedge clk)
	begin
		if (lookup)
			cmp_tag_q <= adr_tag;
	end

	cache_tag_if #(.LINES(LINES), .WAYS(WAYS), .TAG_W(TAG_W)) tag_bus ();

	assign tag_bus.ndx     = adr_ndx;
	assign tag_bus.cmp_tag = cmp_tag_q;

	// ==============================
	// Blocks
	// ==============================

	cache_tag_store #(.LINES(LINES), .WAYS(WAYS), .AWID(AWID), .LINE_BYTES(LINE_BYTES),
		.DATA_W(DATA_W)) u_tag_store (.clk(clk), .rst_n(rst_n), .fill(fill),
		.invalidate(invalidate), .fill_ndx(adr_ndx), .fill_tag(adr_tag),
		.victim_way(victim_way), .rd_en(lookup), .tag_bus(tag_bus.store),
		.fill_valid_bits(fill_valid_bits));

	cache_hit #(.LINES(LINES), .WAYS(WAYS), .AWID(AWID), .LINE_BYTES(LINE_BYTES),
		.DATA_W(DATA_W)) u_hit (.clk(clk), .rst_n(rst_n), .ce(resp_valid),
		.tag_bus(tag_bus.hit), .hit(hit), .rway(rway), .cv(cv));

	cache_victim #(.LINES(LINES), .WAYS(WAYS), .AWID(AWID), .LINE_BYTES(LINE_BYTES),
		.DATA_W(DATA_W)) u_victim (.clk(clk), .rst_n(rst_n), .fill(fill),
		.fill_ndx(adr_ndx), .fill_valid_bits(fill_valid_bits), .victim_way(victim_way));

	// The data read uses the live index and picks its way with rway a cycle later
	cache_data_store #(.LINES(LINES), .WAYS(WAYS), .AWID(AWID), .LINE_BYTES(LINE_BYTES),
		.DATA_W(DATA_W)) u_data_store (.clk(clk), .fill(fill), .fill_ndx(adr_ndx),
		.victim_way(victim_way), .fill_data(fill_data), .rd_en(lookup), .rd_ndx(adr_ndx),
		.rd_way(rway), .rdata(rdata));

endmodule

// File: verif/tb_clk_gen.sv
// Free-running clock from time zero. rst_n is released by a non-blocking write on a rising edge
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	// Half a period high, half a period low
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset is held low for the first RESET_CYCLES rising edges
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: verif/cache_hit_chk.sv
// Bound into cache_top with its WAYS. Nothing is checked while rst_n is low
`timescale 1ns/1ps

module cache_hit_chk #(
	parameter int WAYS = cache_pkg::DEF_WAYS
) (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    lookup,
	input logic                    fill,
	input logic                    resp_valid,
	input logic                    hit,
	input logic [$clog2(WAYS)-1:0] rway
);
	import cache_pkg::*;

	// Number of assertion failures seen so far
	int fail_count = 0;

	if (WAYS > MAX_WAYS) begin : g_too_many_ways
		$error("cache_hit_chk: WAYS is above the supported maximum");
	end

	// ==============================
	// Protocol and response checks
	// ==============================

	// Lookup and fill share adr, so they can never be issued together
	a_no_fill_with_lookup: assert property (@(posedge clk) disable iff (!rst_n)
		!(fill && lookup))
	else
	begin
		$error("fill and lookup are high in the same cycle");
		fail_count++;
	end

	// A hit is only reported in a response cycle
	a_hit_needs_resp: assert property (@(posedge clk) disable iff (!rst_n)
		hit |-> resp_valid)
	else
	begin
		$error("hit is high while resp_valid is low");
		fail_count++;
	end

	// A cycle without a hit keeps showing the way of the last hit
	a_rway_held: assert property (@(posedge clk) disable iff (!rst_n)
		!hit |-> $stable(rway))
	else
	begin
		$error("rway changed in a cycle without a hit");
		fail_count++;
	end

endmodule

bind cache_top cache_hit_chk #(
	.WAYS(WAYS)
) u_hit_chk (
	.clk(clk),
	.rst_n(rst_n),
	.lookup(lookup),
	.fill(fill),
	.resp_valid(resp_valid),
	.hit(hit),
	.rway(rway)
);

// File: verif/cache_top_tb.sv
// Default geometry only. The model assumes a tag is never held in two ways of a set
`timescale 1ns/1ps

module cache_top_tb;
	import cache_pkg::*;

	localparam int LINES      = DEF_LINES;
	localparam int WAYS       = DEF_WAYS;
	localparam int AWID       = DEF_AWID;
	localparam int LINE_BYTES = DEF_LINE_BYTES;
	localparam int DATA_W     = DEF_DATA_W;
	localparam int IDX_W      = $clog2(LINES);
	localparam int OFF_W      = $clog2(LINE_BYTES);
	localparam int TAG_W      = AWID - IDX_W - OFF_W;
	localparam int WAY_W      = $clog2(WAYS);
	localparam int RAND_OPS   = 200;
	// Rising edges per test, where a fill or invalidate takes 2 and a directed lookup 3
	localparam int RUN_CYCLES = 6 + 12 + 5 + 23 + 25 + 43 + RAND_OPS + 2;
	localparam int TIMEOUT    = RUN_CYCLES + 100;

	logic              clk;
	logic              rst_n;
	logic              lookup;
	logic              fill;
	logic              invalidate;
	logic [AWID-1:0]   adr;
	logic [DATA_W-1:0] fill_data;
	logic              resp_valid;
	logic              hit;
	logic [WAY_W-1:0]  rway;
	logic [DATA_W-1:0] rdata;
	logic              cv;

	// Reference model of tags, valid bits, lines, round-robin pointers and the held way
	logic [TAG_W-1:0]  m_tag [WAYS][LINES];
	bit                m_valid [WAYS][LINES];
	logic [DATA_W-1:0] m_data [WAYS][LINES];
	logic [WAY_W-1:0]  m_ptr [LINES];
	logic [WAY_W-1:0]  m_rway;

	// Expected responses of the back-to-back random test, one entry per cycle
	bit                r_lk [RAND_OPS+2];
	bit                r_hit [RAND_OPS+2];
	logic [WAY_W-1:0]  r_way [RAND_OPS+2];
	logic [DATA_W-1:0] r_data [RAND_OPS+2];
	bit                r_cv [RAND_OPS+2];

	logic [AWID-1:0] seen_adr [$];
	logic [31:0]     lfsr = 32'd32;
	int              checks = 0;
	int              errors = 0;
	int              chk_mark = 0;
	int              err_mark = 0;
	int              tests_done = 0;
	int              cycles = 0;

	tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) u_clk_gen (.clk(clk), .rst_n(rst_n));

	cache_top #(
		.LINES(LINES),
		.WAYS(WAYS),
		.AWID(AWID),
		.LINE_BYTES(LINE_BYTES),
		.DATA_W(DATA_W)
	) DUT (
		.clk(clk),
		.rst_n(rst_n),
		.lookup(lookup),
		.fill(fill),
		.invalidate(invalidate),
		.adr(adr),
		.fill_data(fill_data),
		.resp_valid(resp_valid),
		.hit(hit),
		.rway(rway),
		.rdata(rdata),
		.cv(cv)
	);

	// ==============================
	// Helpers
	// ==============================

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_val(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	function automatic logic [AWID-1:0] make_adr(input int tag, input int ndx, input int off);
		return {tag[TAG_W-1:0], ndx[IDX_W-1:0], off[OFF_W-1:0]};
	endfunction

	function automatic logic [IDX_W-1:0] adr_ndx(input logic [AWID-1:0] a);
		return a[OFF_W +: IDX_W];
	endfunction

	function automatic logic [TAG_W-1:0] adr_tag(input logic [AWID-1:0] a);
		return a[AWID-1 -: TAG_W];
	endfunction

	// Line contents that differ for every n
	function automatic logic [DATA_W-1:0] line_pat(input int n);
		return {4{32'hA5C30000 ^ 32'(n)}};
	endfunction

	task automatic start_test();
		chk_mark = checks;
		err_mark = errors;
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		$display("test %s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
	endtask

	// ==============================
	// Reference model
	// ==============================

	task automatic clear_model();
		for (int s = 0; s < LINES; s++)
		begin
			m_ptr[s] = '0;
			for (int w = 0; w < WAYS; w++)
				m_valid[w][s] = 1'b0;
		end
		m_rway = '0;
	endtask

	function automatic bit holds_line(input logic [AWID-1:0] a);
		bit found;
		found = 1'b0;
		for (int w = 0; w < WAYS; w++)
			if (m_valid[w][adr_ndx(a)] && m_tag[w][adr_ndx(a)] == adr_tag(a))
				found = 1'b1;
		return found;
	endfunction

	// Lowest free way first, otherwise the set pointer, which then moves on
	task automatic place_line(input logic [AWID-1:0] a, input logic [DATA_W-1:0] d,
		output logic [WAY_W-1:0] way);
		logic [IDX_W-1:0] ndx;
		bit full;
		ndx = adr_ndx(a);
		full = 1'b1;
		way = m_ptr[ndx];
		for (int w = 0; w < WAYS; w++)
		begin
			if (full && !m_valid[w][ndx])
			begin
				way = WAY_W'(w);
				full = 1'b0;
			end
		end
		if (full)
			m_ptr[ndx] = m_ptr[ndx] + 1'b1;
		m_tag[way][ndx] = adr_tag(a);
		m_valid[way][ndx] = 1'b1;
		m_data[way][ndx] = d;
	endtask

	// A miss keeps the way of the last hit
	task automatic predict_lookup(input logic [AWID-1:0] a, output bit e_hit,
		output logic [WAY_W-1:0] e_way, output logic [DATA_W-1:0] e_data, output bit e_cv);
		logic [IDX_W-1:0] ndx;
		ndx = adr_ndx(a);
		e_hit = 1'b0;
		e_cv = 1'b0;
		e_data = '0;
		for (int w = 0; w < WAYS; w++)
		begin
			e_cv = e_cv | m_valid[w][ndx];
			if (m_valid[w][ndx] && m_tag[w][ndx] == adr_tag(a))
			begin
				e_hit = 1'b1;
				m_rway = WAY_W'(w);
				e_data = m_data[w][ndx];
			end
		end
		e_way = m_rway;
	endtask

	// ==============================
	// Bus operations
	// ==============================

	// The victim way of the DUT is compared with the way the test scenario expects
	task automatic fill_line(input logic [AWID-1:0] a, input logic [DATA_W-1:0] d,
		input int exp_way);
		logic [WAY_W-1:0] way;
		place_line(a, d, way);
		seen_adr.push_back(a);
		@(posedge clk);
		fill <= 1'b1;
		adr <= a;
		fill_data <= d;
		// The victim is chosen while fill is high
		@(negedge clk);
		check_val("victim_way", DATA_W'(DUT.victim_way), DATA_W'(exp_way));
		@(posedge clk);
		fill <= 1'b0;
	endtask

	task automatic lookup_check(input logic [AWID-1:0] a);
		bit               e_hit;
		logic [WAY_W-1:0] e_way;
		logic [DATA_W-1:0] e_data;
		bit               e_cv;
		predict_lookup(a, e_hit, e_way, e_data, e_cv);
		@(posedge clk);
		lookup <= 1'b1;
		adr <= a;
		@(posedge clk);
		lookup <= 1'b0;
		// Response cycle
		@(negedge clk);
		check_val("resp_valid", DATA_W'(resp_valid), DATA_W'(1'b1));
		check_val("hit", DATA_W'(hit), DATA_W'(e_hit));
		check_val("rway", DATA_W'(rway), DATA_W'(e_way));
		if (e_hit)
			check_val("rdata", rdata, e_data);
		// cv follows one cycle later
		@(posedge clk);
		@(negedge clk);
		check_val("cv", DATA_W'(cv), DATA_W'(e_cv));
	endtask

	task automatic invalidate_all();
		@(posedge clk);
		invalidate <= 1'b1;
		@(posedge clk);
		invalidate <= 1'b0;
		for (int s = 0; s < LINES; s++)
			for (int w = 0; w < WAYS; w++)
				m_valid[w][s] = 1'b0;
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic lookups_after_reset();
		logic [AWID-1:0] a [4];
		start_test();
		a[0] = make_adr(1, 0, 0);
		a[1] = make_adr(2, 7, 4);
		a[2] = make_adr('h3FFFFF, 63, 15);
		a[3] = make_adr(5, 9, 0);
		for (int i = 0; i < 4; i++)
		begin
			seen_adr.push_back(a[i]);
			lookup_check(a[i]);
		end
		finish_test("reset_lookups");
	endtask

	task automatic fill_then_hit();
		start_test();
		fill_line(make_adr('h1234, 5, 8), line_pat('h55), 0);
		lookup_check(make_adr('h1234, 5, 8));
		finish_test("fill_hit");
	endtask

	// Set 9 is filled way by way, then a fifth tag misses
	task automatic fill_one_set();
		start_test();
		for (int t = 0; t < 4; t++)
			fill_line(make_adr('h100 + t, 9, 0), line_pat('h100 + t), t);
		for (int t = 0; t < 4; t++)
			lookup_check(make_adr('h100 + t, 9, 0));
		seen_adr.push_back(make_adr('h104, 9, 0));
		lookup_check(make_adr('h104, 9, 0));
		finish_test("fill_set");
	endtask

	task automatic evict_round_robin();
		start_test();
		fill_line(make_adr('h104, 9, 0), line_pat('h104), 0);
		for (int t = 0; t < 5; t++)
			lookup_check(make_adr('h100 + t, 9, 0));
		fill_line(make_adr('h105, 9, 0), line_pat('h105), 1);
		lookup_check(make_adr('h101, 9, 0));
		lookup_check(make_adr('h105, 9, 0));
		finish_test("evict");
	endtask

	task automatic invalidate_then_refill();
		int n;
		start_test();
		invalidate_all();
		n = seen_adr.size();
		for (int i = 0; i < n; i++)
			lookup_check(seen_adr[i]);
		// An empty set fills from way 0 whatever its pointer says
		fill_line(make_adr('h106, 9, 0), line_pat('h106), 0);
		lookup_check(make_adr('h106, 9, 0));
		finish_test("invalidate");
	endtask

	// Fills and lookups back to back, with each response checked one cycle after issue
	task automatic random_ops();
		logic [31:0]       op;
		logic [31:0]       ndx;
		logic [31:0]       tag;
		logic [31:0]       off;
		logic [31:0]       v;
		logic [AWID-1:0]   a;
		logic [DATA_W-1:0] d;
		logic [WAY_W-1:0]  way;
		bit                e_hit;
		logic [WAY_W-1:0]  e_way;
		logic [DATA_W-1:0] e_data;
		bit                e_cv;
		start_test();
		for (int c = 0; c < RAND_OPS + 2; c++)
		begin
			@(posedge clk);
			r_lk[c] = 1'b0;
			fill <= 1'b0;
			lookup <= 1'b0;
			if (c < RAND_OPS)
			begin
				take_bits(1, op);
				take_bits(2, ndx);
				take_bits(3, tag);
				take_bits(4, off);
				a = make_adr('h2A0 + int'(tag), 48 + int'(ndx), int'(off));
				// A fill of a tag that is already present turns into a lookup
				if (op[0] && !holds_line(a))
				begin
					take_bits(32, v);
					d = {v, ~v, a, 32'(c)};
					place_line(a, d, way);
					fill <= 1'b1;
					adr <= a;
					fill_data <= d;
				end
				else
				begin
					predict_lookup(a, e_hit, e_way, e_data, e_cv);
					r_lk[c] = 1'b1;
					r_hit[c] = e_hit;
					r_way[c] = e_way;
					r_data[c] = e_data;
					r_cv[c] = e_cv;
					lookup <= 1'b1;
					adr <= a;
				end
			end
			@(negedge clk);
			if (c >= 1)
			begin
				check_val("resp_valid", DATA_W'(resp_valid), DATA_W'(r_lk[c-1]));
				if (r_lk[c-1])
				begin
					check_val("hit", DATA_W'(hit), DATA_W'(r_hit[c-1]));
					check_val("rway", DATA_W'(rway), DATA_W'(r_way[c-1]));
					if (r_hit[c-1])
						check_val("rdata", rdata, r_data[c-1]);
				end
			end
			if (c >= 2 && r_lk[c-2])
				check_val("cv", DATA_W'(cv), DATA_W'(r_cv[c-2]));
		end
		finish_test("random");
	endtask

	// ==============================
	// Run control
	// ==============================

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
			$display("Something failed");
			$finish;
		end
	end

	initial
	begin
		lookup = 1'b0;
		fill = 1'b0;
		invalidate = 1'b0;
		adr = '0;
		fill_data = '0;
		clear_model();
		wait (rst_n === 1'b1);
		lookups_after_reset();
		fill_then_hit();
		fill_one_set();
		evict_round_robin();
		invalidate_then_refill();
		random_ops();
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests_done,
			checks, errors, DUT.u_hit_chk.fail_count);
		if (errors == 0 && DUT.u_hit_chk.fail_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: cache_top.f
hw/cache_pkg.sv
hw/cache_tag_if.sv
hw/cache_tag_store.sv
hw/cache_hit.sv
hw/cache_victim.sv
hw/cache_data_store.sv
hw/cache_top.sv
verif/tb_clk_gen.sv
verif/cache_hit_chk.sv
verif/cache_top_tb.sv

// File: Makefile
# Verilator build and run of the cache lookup testbench

TOP = cache_top_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and pass only on the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert --top-module $(TOP) -f cache_top.f -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
